// File: eth_gen_pkg.sv
`default_nettype none

package eth_gen_pkg;

   // --------------------------------------------------
   // generator states, one per frame field
   // --------------------------------------------------
   typedef enum logic [3:0]
   {
      idle,
      prmbl,
      sfd,
      dst,
      src,
      tag,
      len,
      data,
      pad,
      crc,
      ipg
   } gen_state_e;

   typedef logic [7:0]  byte_t;      // one gmii octet
   typedef logic [47:0] mac_addr_t;
   typedef logic [15:0] field16_t;   // length, type, vlan ctl, ipg

   // --------------------------------------------------
   // frame constants
   // --------------------------------------------------
   localparam byte_t preamble_byte_c = 8'h55;
   localparam byte_t sfd_byte_c      = 8'hD5;
   localparam byte_t bad_sfd_byte_c  = 8'hF5;   // sent under preamble error

   localparam field16_t vlan_tpid_c = 16'h8100;

   // ethernet fcs polynomial, register starts all ones
   localparam logic [31:0] crc_poly_c = 32'h04C11DB7;
   localparam logic [31:0] crc_init_c = 32'hFFFFFFFF;

   localparam field16_t pos_cnt_max_c = 16'd65535;   // counters stop here

endpackage

`default_nettype wire

// File: frame_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface frame_cmd_if;
   import eth_gen_pkg::*;

   mac_addr_t  dst;
   mac_addr_t  src;
   logic [4:0] prmble_len;   // preamble bytes before sfd
   field16_t   vlan_ctl;
   field16_t   len;          // payload length
   field16_t   frmtype;      // non-zero replaces len on the wire
   byte_t      cntstart;
   byte_t      cntstep;
   field16_t   ipg_len;

   logic mac_reverse;        // addresses msb byte first
   logic vlan_en;
   logic pad_en;
   logic prmbl_err;
   logic payload_err;
   logic crc_err;

   modport capture_mp (
      output dst, src, prmble_len, vlan_ctl, len, frmtype, cntstart, cntstep, ipg_len,
      output mac_reverse, vlan_en, pad_en, prmbl_err, payload_err, crc_err
   );

   modport seq_mp (
      input dst, src, prmble_len, vlan_ctl, len, frmtype, cntstart, cntstep, ipg_len,
      input mac_reverse, vlan_en, pad_en, prmbl_err, payload_err, crc_err
   );

endinterface

`default_nettype wire

// File: eth_cmd_capture.sv
`timescale 1ns/100ps
`default_nettype none

module eth_cmd_capture (
   input  logic                  rx_clk_gen_i,
   input  logic                  reset_i,
   input  logic                  start_i,
   input  logic                  seq_idle_i,
   input  eth_gen_pkg::mac_addr_t dst_i,
   input  eth_gen_pkg::mac_addr_t src_i,
   input  logic [4:0]            prmble_len_i,
   input  eth_gen_pkg::field16_t vlan_ctl_i,
   input  eth_gen_pkg::field16_t len_i,
   input  eth_gen_pkg::field16_t frmtype_i,
   input  eth_gen_pkg::field16_t ipg_len_i,
   input  eth_gen_pkg::byte_t    cntstart_i,
   input  eth_gen_pkg::byte_t    cntstep_i,
   input  logic                  mac_reverse_i,
   input  logic                  vlan_en_i,
   input  logic                  pad_en_i,
   input  logic                  prmbl_err_i,
   input  logic                  payload_err_i,
   input  logic                  crc_err_i,
   frame_cmd_if.capture_mp       cmd
);

   logic load;

   assign load = start_i && seq_idle_i;   // same edge the sequencer leaves idle

   always_ff @(posedge rx_clk_gen_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         cmd.dst         <= '0;
         cmd.src         <= '0;
         cmd.prmble_len  <= 5'd8;   // standard 7 + 1 default
         cmd.vlan_ctl    <= '0;
         cmd.len         <= '0;
         cmd.frmtype     <= '0;
         cmd.cntstart    <= '0;
         cmd.cntstep     <= '0;
         cmd.ipg_len     <= '0;
         cmd.mac_reverse <= 1'b0;
         cmd.vlan_en     <= 1'b0;
         cmd.pad_en      <= 1'b0;
         cmd.prmbl_err   <= 1'b0;
         cmd.payload_err <= 1'b0;
         cmd.crc_err     <= 1'b0;
      end
      else if (load)
      begin
         cmd.dst         <= dst_i;
         cmd.src         <= src_i;
         cmd.prmble_len  <= prmble_len_i;
         cmd.vlan_ctl    <= vlan_ctl_i;
         cmd.len         <= len_i;
         cmd.frmtype     <= frmtype_i;
         cmd.cntstart    <= cntstart_i;
         cmd.cntstep     <= cntstep_i;
         cmd.ipg_len     <= ipg_len_i;
         cmd.mac_reverse <= mac_reverse_i;
         cmd.vlan_en     <= vlan_en_i;
         cmd.pad_en      <= pad_en_i;
         cmd.prmbl_err   <= prmbl_err_i;
         cmd.payload_err <= payload_err_i;
         cmd.crc_err     <= crc_err_i;
      end
   end

endmodule

`default_nettype wire

// File: eth_frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module eth_frame_sequencer #(
   parameter int min_frame_len_p = 60
) (
   input  logic               rx_clk_gen_i,
   input  logic               reset_i,
   input  logic               start_i,
   frame_cmd_if.seq_mp        cmd,
   input  logic [31:0]        crc_value_i,
   output logic               seq_idle_o,
   output logic               crc_init_o,
   output logic               crc_en_o,
   output eth_gen_pkg::byte_t next_byte_o,
   output eth_gen_pkg::byte_t line_byte_o,
   output logic               line_valid_o,
   output logic               frame_start_o,
   output logic               done_o
);
   import eth_gen_pkg::*;

   gen_state_e state;
   gen_state_e state_nxt;
   field16_t   fld_cnt;   // byte index inside current field
   field16_t   pos_cnt;   // bytes loaded since first dst byte
   byte_t      byte_q;    // byte register, one cycle behind state
   byte_t      byte_nxt;
   byte_t      data_cnt;  // running payload value
   byte_t      sfd_sel;
   byte_t      crc_sel;
   byte_t      fcs_byte;
   logic [2:0] mac_idx;
   field16_t   len_field;
   logic       in_body;
   logic       last_payload;
   logic       need_pad;

   assign seq_idle_o = (state == idle);
   assign in_body    = state inside {dst, src, tag, len, data, pad};

   // crc sees exactly the bytes entering the byte register
   assign crc_init_o  = (state == idle);
   assign crc_en_o    = in_body;
   assign next_byte_o = byte_nxt;
   assign line_byte_o = byte_q;

   // --------------------------------------------------
   // field helpers
   // --------------------------------------------------
   assign sfd_sel      = cmd.prmbl_err ? bad_sfd_byte_c : sfd_byte_c;
   assign mac_idx      = cmd.mac_reverse ? 3'd5 - fld_cnt[2:0] : fld_cnt[2:0];
   assign len_field    = (cmd.frmtype != '0) ? cmd.frmtype : cmd.len;
   assign last_payload = (fld_cnt >= cmd.len - 16'd1);
   // true while the byte now selected still leaves the frame short
   assign need_pad     = cmd.pad_en && (pos_cnt < field16_t'(min_frame_len_p - 1));
   assign crc_sel      = crc_value_i[8 * (3 - fld_cnt[1:0]) +: 8];   // msb byte first

   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         fcs_byte[i] = ~crc_sel[7 - i];   // bit reversed and inverted
      end
      if (cmd.crc_err && fld_cnt[1:0] == 2'd2)
      begin
         fcs_byte = ~fcs_byte;   // corrupt third fcs byte
      end
   end

   // --------------------------------------------------
   // next state and next byte
   // --------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      byte_nxt  = '0;
      case (state)
         idle:
         begin
            if (start_i)
            begin
               state_nxt = prmbl;   // zero length handled there
            end
         end
         prmbl:
         begin
            if (cmd.prmble_len == '0)
            begin
               byte_nxt  = sfd_sel;
               state_nxt = dst;
            end
            else
            begin
               byte_nxt = preamble_byte_c;
               if (fld_cnt >= {11'd0, cmd.prmble_len} - 16'd1)
               begin
                  state_nxt = sfd;
               end
            end
         end
         sfd:
         begin
            byte_nxt  = sfd_sel;
            state_nxt = dst;
         end
         dst:
         begin
            byte_nxt = cmd.dst[{mac_idx, 3'b000} +: 8];
            if (fld_cnt == 16'd5)
            begin
               state_nxt = src;
            end
         end
         src:
         begin
            byte_nxt = cmd.src[{mac_idx, 3'b000} +: 8];
            if (fld_cnt == 16'd5)
            begin
               state_nxt = cmd.vlan_en ? tag : len;
            end
         end
         tag:
         begin
            case (fld_cnt[1:0])
               2'd0:    byte_nxt = vlan_tpid_c[15:8];
               2'd1:    byte_nxt = vlan_tpid_c[7:0];
               2'd2:    byte_nxt = cmd.vlan_ctl[15:8];
               default: byte_nxt = cmd.vlan_ctl[7:0];
            endcase
            if (fld_cnt == 16'd3)
            begin
               state_nxt = len;
            end
         end
         len:
         begin
            if (fld_cnt == '0)
            begin
               byte_nxt = len_field[15:8];
            end
            else
            begin
               byte_nxt = len_field[7:0];
               if (cmd.len == '0)
               begin
                  state_nxt = need_pad ? pad : crc;   // empty payload
               end
               else
               begin
                  state_nxt = data;
               end
            end
         end
         data:
         begin
            if (fld_cnt == 16'd0)
            begin
               byte_nxt = cmd.cntstart;
            end
            else if (fld_cnt == 16'd1)
            begin
               byte_nxt = cmd.cntstep;
            end
            else
            begin
               byte_nxt = data_cnt;
            end
            if (last_payload)
            begin
               if (cmd.payload_err)
               begin
                  byte_nxt = byte_q;   // repeat previous byte
               end
               state_nxt = need_pad ? pad : crc;
            end
         end
         pad:
         begin
            if (!need_pad)
            begin
               state_nxt = crc;
            end
         end
         crc:
         begin
            byte_nxt = fcs_byte;
            if (fld_cnt == 16'd3)
            begin
               state_nxt = (cmd.ipg_len != '0) ? ipg : idle;
            end
         end
         ipg:
         begin
            if (fld_cnt >= cmd.ipg_len - 16'd1)
            begin
               state_nxt = idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   // --------------------------------------------------
   // control registers
   // --------------------------------------------------
   always_ff @(posedge rx_clk_gen_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         state         <= idle;
         fld_cnt       <= '0;
         pos_cnt       <= '0;
         line_valid_o  <= 1'b0;
         frame_start_o <= 1'b0;
         done_o        <= 1'b1;
      end
      else
      begin
         state <= state_nxt;
         if (state_nxt != state)
         begin
            fld_cnt <= '0;   // new field
         end
         else if (fld_cnt != pos_cnt_max_c)
         begin
            fld_cnt <= fld_cnt + 16'd1;
         end
         if (!in_body)
         begin
            pos_cnt <= '0;
         end
         else if (pos_cnt != pos_cnt_max_c)
         begin
            pos_cnt <= pos_cnt + 16'd1;
         end
         line_valid_o  <= (state != idle) && (state != ipg);
         frame_start_o <= start_i && (state == idle);
         done_o        <= (state == idle) ? !start_i : 1'b0;
      end
   end

   // payload datapath
   always_ff @(posedge rx_clk_gen_i)
   begin
      byte_q <= byte_nxt;
      if (state == data)
      begin
         if (fld_cnt == 16'd0)
         begin
            data_cnt <= cmd.cntstart;
         end
         else if (fld_cnt != 16'd1)
         begin
            data_cnt <= data_cnt + cmd.cntstep;   // wraps mod 256
         end
      end
   end

endmodule

`default_nettype wire

// File: eth_crc32.sv
`timescale 1ns/100ps
`default_nettype none

module eth_crc32 (
   input  logic               rx_clk_gen_i,
   input  logic               reset_i,
   input  logic               crc_init_i,
   input  logic               crc_en_i,
   input  eth_gen_pkg::byte_t byte_i,
   output logic [31:0]        crc_value_o
);
   import eth_gen_pkg::*;

   logic [31:0] crc_q;
   logic [31:0] crc_nxt;

   // --------------------------------------------------
   // one byte per clock, lsb first
   // --------------------------------------------------
   always_comb
   begin
      crc_nxt = crc_q;
      for (int i = 0; i < 8; i++)
      begin
         if (byte_i[i] ^ crc_nxt[31])
         begin
            crc_nxt = {crc_nxt[30:0], 1'b0} ^ crc_poly_c;
         end
         else
         begin
            crc_nxt = {crc_nxt[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge rx_clk_gen_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         crc_q <= crc_init_c;
      end
      else if (crc_init_i)
      begin
         crc_q <= crc_init_c;   // held between frames
      end
      else if (crc_en_i)
      begin
         crc_q <= crc_nxt;
      end
   end

   assign crc_value_o = crc_q;   // raw remainder, sequencer inverts

endmodule

`default_nettype wire

// File: gmii_rx_drive.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_drive (
   input  logic               rx_clk_gen_i,
   input  logic               reset_i,
   input  logic               line_valid_i,
   input  logic               frame_start_i,
   input  eth_gen_pkg::byte_t line_byte_i,
   output eth_gen_pkg::byte_t rxd_o,
   output logic               rx_dv_o,
   output logic               sop_o,
   output logic               eop_o
);

   logic start_dly;   // high with the first line_valid cycle

   // --------------------------------------------------
   // line register
   // --------------------------------------------------
   always_ff @(posedge rx_clk_gen_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         rxd_o     <= '0;
         rx_dv_o   <= 1'b0;
         start_dly <= 1'b0;
         sop_o     <= 1'b0;
      end
      else
      begin
         rxd_o     <= line_valid_i ? line_byte_i : '0;   // quiet bus when idle
         rx_dv_o   <= line_valid_i;
         start_dly <= frame_start_i;
         sop_o     <= start_dly;   // lines up with first rx_dv_o byte
      end
   end

   // the sequencer valid runs one cycle ahead of rx_dv_o, so a falling
   // edge there marks the byte now on the line as the last one
   assign eop_o = rx_dv_o && !line_valid_i;

endmodule

`default_nettype wire

// File: eth_gen_top.sv
`timescale 1ns/100ps
`default_nettype none

module eth_gen_top #(
   parameter int min_frame_len_p = 60   // bytes from dst up to fcs
) (
   input  logic                   rx_clk_gen_i,
   input  logic                   reset_i,
   input  logic                   start_i,
   input  eth_gen_pkg::mac_addr_t dst_i,
   input  eth_gen_pkg::mac_addr_t src_i,
   input  logic [4:0]             prmble_len_i,
   input  eth_gen_pkg::field16_t  vlan_ctl_i,
   input  eth_gen_pkg::field16_t  len_i,
   input  eth_gen_pkg::field16_t  frmtype_i,
   input  eth_gen_pkg::byte_t     cntstart_i,
   input  eth_gen_pkg::byte_t     cntstep_i,
   input  eth_gen_pkg::field16_t  ipg_len_i,
   input  logic                   mac_reverse_i,
   input  logic                   vlan_en_i,
   input  logic                   pad_en_i,
   input  logic                   prmbl_err_i,
   input  logic                   payload_err_i,
   input  logic                   crc_err_i,
   output eth_gen_pkg::byte_t     rxd_o,
   output logic                   rx_dv_o,
   output logic                   sop_o,
   output logic                   eop_o,
   output logic                   done_o
);
   import eth_gen_pkg::*;

   logic        seq_idle;
   logic        crc_init;
   logic        crc_en;
   byte_t       next_byte;
   logic [31:0] crc_value;
   byte_t       line_byte;
   logic        line_valid;
   logic        frame_start;

   frame_cmd_if u_cmd_if ();

   eth_cmd_capture u_cmd_capture (
      .rx_clk_gen_i  (rx_clk_gen_i),
      .reset_i       (reset_i),
      .start_i       (start_i),
      .seq_idle_i    (seq_idle),
      .dst_i         (dst_i),
      .src_i         (src_i),
      .prmble_len_i  (prmble_len_i),
      .vlan_ctl_i    (vlan_ctl_i),
      .len_i         (len_i),
      .frmtype_i     (frmtype_i),
      .ipg_len_i     (ipg_len_i),
      .cntstart_i    (cntstart_i),
      .cntstep_i     (cntstep_i),
      .mac_reverse_i (mac_reverse_i),
      .vlan_en_i     (vlan_en_i),
      .pad_en_i      (pad_en_i),
      .prmbl_err_i   (prmbl_err_i),
      .payload_err_i (payload_err_i),
      .crc_err_i     (crc_err_i),
      .cmd           (u_cmd_if.capture_mp)
   );

   eth_frame_sequencer #(
      .min_frame_len_p (min_frame_len_p)
   ) u_sequencer (
      .rx_clk_gen_i  (rx_clk_gen_i),
      .reset_i       (reset_i),
      .start_i       (start_i),
      .cmd           (u_cmd_if.seq_mp),
      .crc_value_i   (crc_value),
      .seq_idle_o    (seq_idle),
      .crc_init_o    (crc_init),
      .crc_en_o      (crc_en),
      .next_byte_o   (next_byte),
      .line_byte_o   (line_byte),
      .line_valid_o  (line_valid),
      .frame_start_o (frame_start),
      .done_o        (done_o)
   );

   eth_crc32 u_crc32 (
      .rx_clk_gen_i (rx_clk_gen_i),
      .reset_i      (reset_i),
      .crc_init_i   (crc_init),
      .crc_en_i     (crc_en),
      .byte_i       (next_byte),
      .crc_value_o  (crc_value)
   );

   gmii_rx_drive u_rx_drive (
      .rx_clk_gen_i  (rx_clk_gen_i),
      .reset_i       (reset_i),
      .line_valid_i  (line_valid),
      .frame_start_i (frame_start),
      .line_byte_i   (line_byte),
      .rxd_o         (rxd_o),
      .rx_dv_o       (rx_dv_o),
      .sop_o         (sop_o),
      .eop_o         (eop_o)
   );

endmodule

`default_nettype wire

// File: tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// --------------------------------------------------
// reference crc-32, reflected form
// --------------------------------------------------
function automatic logic [31:0] crc32_ref(input logic [7:0] data[$]);
   logic [31:0] c;
   c = 32'hFFFFFFFF;
   foreach (data[n])
   begin
      c = c ^ {24'd0, data[n]};
      for (int i = 0; i < 8; i++)
      begin
         c = c[0] ? (c >> 1) ^ 32'hEDB88320 : (c >> 1);
      end
   end
   return c;
endfunction

// galois lfsr, one step per bit taken
function automatic int unsigned lfsr_bits(input int n);
   int unsigned v;
   v = 0;
   for (int i = 0; i < n; i++)
   begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'hA3000000 : (lfsr_q >> 1);
   end
   return v;
endfunction

// expected line bytes for one pattern word, into exp_q
function automatic void build_frame(input logic [191:0] p);
   logic [7:0]  body[$];
   logic [7:0]  b;
   logic [15:0] len;
   logic [15:0] lfield;
   logic [7:0]  flags;
   logic [31:0] fcs;
   int          idx;
   len    = p[71:56];
   flags  = p[7:0];
   lfield = (p[55:40] != 16'd0) ? p[55:40] : len;   // type wins when set
   exp_q.delete();
   for (int i = 0; i < int'(p[92:88]); i++)
   begin
      exp_q.push_back(8'h55);
   end
   exp_q.push_back(flags[2] ? 8'hF5 : 8'hD5);
   for (int i = 0; i < 12; i++)
   begin
      idx = flags[5] ? 5 - (i % 6) : i % 6;
      body.push_back((i < 6) ? p[144 + idx * 8 +: 8] : p[96 + idx * 8 +: 8]);
   end
   if (flags[4])
   begin
      body.push_back(8'h81);
      body.push_back(8'h00);
      body.push_back(p[87:80]);
      body.push_back(p[79:72]);
   end
   body.push_back(lfield[15:8]);
   body.push_back(lfield[7:0]);
   for (int k = 0; k < int'(len); k++)
   begin
      if (k == 0)
         b = p[39:32];
      else if (k == 1)
         b = p[31:24];
      else
         b = p[39:32] + 8'((k - 2) * p[31:24]);   // counting payload
      if (flags[1] && k == int'(len) - 1)
         b = body[body.size() - 1];
      body.push_back(b);
   end
   while (flags[3] && body.size() < min_frame_c)
   begin
      body.push_back(8'h00);
   end
   fcs = ~crc32_ref(body);
   foreach (body[n])
   begin
      exp_q.push_back(body[n]);
   end
   for (int i = 0; i < 4; i++)
   begin
      b = fcs[8 * i +: 8];
      exp_q.push_back((flags[0] && i == 2) ? ~b : b);
   end
endfunction

`endif

// File: tb_eth_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eth_gen;

   localparam int clk_period_c = 8;
   localparam int num_pat_c    = 15;
   localparam int min_frame_c  = 60;
   localparam int max_frame_c  = 600;
   localparam int max_ipg_c    = 64;

   logic        rx_clk_gen;
   logic        reset;
   logic        start_i;
   logic [47:0] dst_i;
   logic [47:0] src_i;
   logic [4:0]  prmble_len_i;
   logic [15:0] vlan_ctl_i;
   logic [15:0] len_i;
   logic [15:0] frmtype_i;
   logic [7:0]  cntstart_i;
   logic [7:0]  cntstep_i;
   logic [15:0] ipg_len_i;
   logic        mac_reverse_i;
   logic        vlan_en_i;
   logic        pad_en_i;
   logic        prmbl_err_i;
   logic        payload_err_i;
   logic        crc_err_i;
   logic [7:0]  rxd_o;
   logic        rx_dv_o;
   logic        sop_o;
   logic        eop_o;
   logic        done_o;

   logic [191:0] patterns[num_pat_c];
   logic [7:0]   exp_q[$];
   logic [31:0]  lfsr_q = 32'hb061;
   logic [15:0]  exp_ipg;
   int           frames_seen = 0;

   `include "tb_frame_model.svh"

   eth_gen_top #(
      .min_frame_len_p (min_frame_c)
   ) u_eth_gen_top (
      .rx_clk_gen_i  (rx_clk_gen),
      .reset_i       (reset),
      .start_i       (start_i),
      .dst_i         (dst_i),
      .src_i         (src_i),
      .prmble_len_i  (prmble_len_i),
      .vlan_ctl_i    (vlan_ctl_i),
      .len_i         (len_i),
      .frmtype_i     (frmtype_i),
      .cntstart_i    (cntstart_i),
      .cntstep_i     (cntstep_i),
      .ipg_len_i     (ipg_len_i),
      .mac_reverse_i (mac_reverse_i),
      .vlan_en_i     (vlan_en_i),
      .pad_en_i      (pad_en_i),
      .prmbl_err_i   (prmbl_err_i),
      .payload_err_i (payload_err_i),
      .crc_err_i     (crc_err_i),
      .rxd_o         (rxd_o),
      .rx_dv_o       (rx_dv_o),
      .sop_o         (sop_o),
      .eop_o         (eop_o),
      .done_o        (done_o)
   );

   always #(clk_period_c / 2) rx_clk_gen = ~rx_clk_gen;

   // --------------------------------------------------
   // failure reporting
   // --------------------------------------------------
   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic value_fail(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("FAILED time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic plain_fail(input string msg);
      $display("%s at time %0t", msg, $time);
      stop_run();
   endtask

   task automatic apply_command(input logic [191:0] p);
      dst_i         <= p[191:144];
      src_i         <= p[143:96];
      prmble_len_i  <= p[92:88];
      vlan_ctl_i    <= p[87:72];
      len_i         <= p[71:56];
      frmtype_i     <= p[55:40];
      cntstart_i    <= p[39:32];
      cntstep_i     <= p[31:24];
      ipg_len_i     <= p[23:8];
      mac_reverse_i <= p[5];
      vlan_en_i     <= p[4];
      pad_en_i      <= p[3];
      prmbl_err_i   <= p[2];
      payload_err_i <= p[1];
      crc_err_i     <= p[0];
      start_i       <= 1'b1;
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial
   begin
      int unsigned gap;
      rx_clk_gen    = 1'b0;
      reset         = 1'b1;
      start_i       = 1'b0;
      dst_i         = '0;
      src_i         = '0;
      prmble_len_i  = '0;
      vlan_ctl_i    = '0;
      len_i         = '0;
      frmtype_i     = '0;
      cntstart_i    = '0;
      cntstep_i     = '0;
      ipg_len_i     = '0;
      mac_reverse_i = 1'b0;
      vlan_en_i     = 1'b0;
      pad_en_i      = 1'b0;
      prmbl_err_i   = 1'b0;
      payload_err_i = 1'b0;
      crc_err_i     = 1'b0;
      exp_ipg       = '0;
      $readmemh("eth_gen_patterns.txt", patterns);
      repeat (2) @(posedge rx_clk_gen);
      reset <= 1'b0;
      @(posedge rx_clk_gen);
      assert (done_o === 1'b1) else value_fail("done_o", done_o, 1);
      assert (rx_dv_o === 1'b0) else value_fail("rx_dv_o", rx_dv_o, 0);
      assert (sop_o === 1'b0) else value_fail("sop_o", sop_o, 0);
      assert (eop_o === 1'b0) else value_fail("eop_o", eop_o, 0);
      for (int n = 0; n < num_pat_c; n++)
      begin
         while (done_o !== 1'b1)
            @(posedge rx_clk_gen);
         gap = lfsr_bits(4);   // 0..15 idle cycles
         repeat (gap) @(posedge rx_clk_gen);
         build_frame(patterns[n]);
         exp_ipg = patterns[n][23:8];
         apply_command(patterns[n]);
         @(posedge rx_clk_gen);   // accepting edge
         start_i <= 1'b0;
         @(posedge rx_clk_gen);
         assert (done_o === 1'b0) else value_fail("done_o", done_o, 0);
         repeat (3) @(posedge rx_clk_gen);
         start_i <= 1'b1;   // ignored while busy
         dst_i   <= ~dst_i;
         @(posedge rx_clk_gen);
         start_i <= 1'b0;
         while (done_o !== 1'b1)
            @(posedge rx_clk_gen);
         @(posedge rx_clk_gen);
         assert (frames_seen == n + 1) else value_fail("frames_seen", frames_seen, n + 1);
         assert (exp_q.size() == 0) else plain_fail("frame ended before all bytes were sent");
      end
      repeat (20) @(posedge rx_clk_gen);
      $display("NO ERRORS");
      $finish;
   end

   // --------------------------------------------------
   // monitor samples before the dut updates
   // --------------------------------------------------
   always @(posedge rx_clk_gen)
   begin
      static int   cyc = 0;
      static int   last_eop_cyc = -1000;
      static int   last_ipg = 0;
      static logic prev_dv = 1'b0;
      logic        is_first;
      logic        is_last;
      logic [7:0]  exp_b;
      if (!reset)
      begin
         cyc++;
         is_first = rx_dv_o && !prev_dv;
         assert (sop_o === is_first) else value_fail("sop_o", sop_o, is_first);
         if (!rx_dv_o)
         begin
            assert (rxd_o === 8'h00) else value_fail("rxd_o", rxd_o, 0);
            assert (eop_o === 1'b0) else value_fail("eop_o", eop_o, 0);
         end
         else if (exp_q.size() == 0)
         begin
            plain_fail("rx_dv_o high while no frame byte was expected");
         end
         else
         begin
            if (is_first)
            begin
               assert (cyc - last_eop_cyc > last_ipg)
                  else plain_fail("rx_dv_o rose before the inter-packet gap ended");
            end
            is_last = (exp_q.size() == 1);
            exp_b   = exp_q.pop_front();
            assert (rxd_o === exp_b) else value_fail("rxd_o", rxd_o, exp_b);
            assert (eop_o === is_last) else value_fail("eop_o", eop_o, is_last);
            if (is_last)
            begin
               frames_seen++;
               last_eop_cyc = cyc;
               last_ipg     = int'(exp_ipg);
            end
         end
         prev_dv = rx_dv_o;
      end
   end

   // watchdog
   initial
   begin
      #(num_pat_c * (max_frame_c + max_ipg_c + 200) * clk_period_c);
      plain_fail("timeout, the frames did not finish in time");
   end

endmodule

`default_nettype wire

// File: eth_gen_patterns.txt
// dst_src_prmblen_vlanctl_len_frmtype_cntstart_cntstep_ipglen_flags, all hex
// flags bit5 mac_reverse, bit4 vlan_en, bit3 pad_en, bit2 prmbl_err, bit1 payload_err, bit0 crc_err
0180c2000001_001122334455_00_0000_0010_0000_00_01_000c_00
0180c2000001_001122334455_07_0000_0014_0000_10_03_0008_20
a1b2c3d4e5f6_0a0b0c0d0e0f_08_0000_002e_0000_40_02_0010_08
a1b2c3d4e5f6_0a0b0c0d0e0f_08_0000_0005_0000_01_01_0004_08
a1b2c3d4e5f6_0a0b0c0d0e0f_08_0000_0005_0000_01_01_0004_00
ffffffffffff_123456789abc_08_0000_0000_0000_00_00_0006_08
ffffffffffff_123456789abc_08_0000_0000_0000_00_00_0006_00
020000000002_020000000001_07_e123_0012_0000_20_05_000a_10
020000000002_020000000001_07_0064_0008_0800_33_11_000a_38
5a5a5a5a5a5a_a5a5a5a5a5a5_08_0000_000a_0000_80_01_0005_04
5a5a5a5a5a5a_a5a5a5a5a5a5_08_0000_000a_0000_80_01_0005_02
5a5a5a5a5a5a_a5a5a5a5a5a5_08_0000_000a_0000_80_01_0005_01
00aa00bb00cc_11dd22ee33ff_03_f00d_0003_0000_7e_02_0003_3f
0c0d0e0f1011_121314151617_08_0000_0040_0000_00_ff_0000_00
0c0d0e0f1011_121314151617_08_0000_0064_0000_f0_07_0028_00

// File: all.f
+incdir+.
eth_gen_pkg.sv
frame_cmd_if.sv
eth_cmd_capture.sv
eth_frame_sequencer.sv
eth_crc32.sv
gmii_rx_drive.sv
eth_gen_top.sv
tb_eth_gen.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_eth_gen \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_eth_gen > sim.log 2>&1 || echo "simulation returned an error status"
grep -q "ERRORS FOUND" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
